/* Bender.yml */
package:
  name: cbus_mem_target

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cbus_pkg.sv
      - src/cbus_if.sv
      - src/cbus_cmd_intake.sv
      - src/cbus_mem_engine.sv
      - src/cbus_resp_issuer.sv
      - src/cbus_mem_target.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/cbus_target_props.sv
      - test/tb_cbus_mem_target.sv

/* all.f */
+incdir+include
src/cbus_pkg.sv
src/cbus_if.sv
src/cbus_cmd_intake.sv
src/cbus_mem_engine.sv
src/cbus_resp_issuer.sv
src/cbus_mem_target.sv
test/cbus_target_props.sv
test/tb_cbus_mem_target.sv

/* include/cbus_consts.svh */
/*
 * core bus memory target constants
 *   bus field widths, burst limit and memory depth
 */
`ifndef CBUS_CONSTS_SVH
`define CBUS_CONSTS_SVH

`define CBUS_DATA_W     32
`define CBUS_ID_W       4
// a length field of zero stands for the maximum burst
`define CBUS_LEN_W      3
`define CBUS_MAX_BURST  8
`define CBUS_ADDR_W     6
`define CBUS_MEM_DEPTH  64

`endif

/* src/cbus_cmd_intake.sv */
/*
 * command and write data intake
 *   burst FSM with address and beat counters
 *   one memory operation per beat
 */
`include "cbus_consts.svh"

module cbus_cmd_intake (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_mcmd_valid,
  input  cbus_pkg::cmd_kind_e       i_mcmd_kind,
  input  logic [`CBUS_ID_W-1:0]     i_mcmd_id,
  input  logic [`CBUS_ADDR_W-1:0]   i_mcmd_addr,
  input  logic [`CBUS_LEN_W-1:0]    i_mcmd_len,
  output logic                      o_scmd_accept,
  input  logic                      i_mdata_valid,
  input  logic [`CBUS_DATA_W-1:0]   i_mdata,
  input  logic [`CBUS_DATA_W/8-1:0] i_mdata_be,
  input  logic                      i_mdata_last,
  output logic                      o_sdata_accept,
  cbus_op_if.source                 op_out
);
  localparam int CNT_W = `CBUS_LEN_W + 1;

  typedef enum logic [1:0] {
    ST_INIT,
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e                    state;
  cbus_pkg::cmd_kind_e       cur_kind;
  logic [`CBUS_ID_W-1:0]     cur_id;
  logic [`CBUS_ADDR_W-1:0]   addr_q;
  logic [CNT_W-1:0]          len_q;
  logic [CNT_W-1:0]          cnt_q;
  logic [CNT_W-1:0]          cnt_next;
  logic [CNT_W-1:0]          len_in;
  logic                      op_valid;
  cbus_pkg::mem_op_t         op_q;
  logic                      op_free;
  logic                      cmd_fire;
  logic                      data_fire;
  logic                      rd_fire;
  logic                      rd_last;

  assign op_free        = !op_valid || op_out.ready;
  assign o_scmd_accept  = (state == ST_IDLE) && op_free;
  assign o_sdata_accept = (state == ST_WRITE) && op_free;
  assign cmd_fire       = i_mcmd_valid && o_scmd_accept;
  assign data_fire      = i_mdata_valid && o_sdata_accept;
  assign rd_fire        = (state == ST_READ) && op_free;

  // saturates so an overlong write burst never aliases back onto the length
  assign cnt_next = (cnt_q == '1) ? cnt_q : cnt_q + 1'b1;
  assign rd_last  = (cnt_next == len_q);
  assign len_in   = (i_mcmd_len == '0) ? CNT_W'(`CBUS_MAX_BURST) : CNT_W'(i_mcmd_len);

  // ##################
  // burst FSM
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= ST_INIT;
      cur_kind <= cbus_pkg::CMD_READ;
      cur_id   <= '0;
      addr_q   <= '0;
      len_q    <= '0;
      cnt_q    <= '0;
    end else begin
      case (state)
        ST_INIT: state <= ST_IDLE;
        ST_IDLE: begin
          if (cmd_fire) begin
            cur_kind <= i_mcmd_kind;
            cur_id   <= i_mcmd_id;
            addr_q   <= i_mcmd_addr;
            len_q    <= len_in;
            cnt_q    <= '0;
            state    <= (i_mcmd_kind == cbus_pkg::CMD_READ) ? ST_READ : ST_WRITE;
          end
        end
        ST_READ: begin
          if (rd_fire && rd_last) begin
            state <= ST_IDLE;
          end
        end
        ST_WRITE: begin
          if (data_fire && i_mdata_last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
      // address wraps with the memory depth
      if (rd_fire || data_fire) begin
        addr_q <= addr_q + 1'b1;
        cnt_q  <= cnt_next;
      end
    end
  end

  // ##################
  // operation register
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      op_valid <= 1'b0;
    end else if (rd_fire || data_fire) begin
      op_valid <= 1'b1;
    end else if (op_out.ready) begin
      op_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire || data_fire) begin
      op_q.kind <= cur_kind;
      op_q.id   <= cur_id;
      op_q.addr <= addr_q;
      op_q.data <= i_mdata;
      op_q.be   <= i_mdata_be;
      if (rd_fire) begin
        op_q.resp_due <= 1'b1;
        op_q.last     <= rd_last;
        op_q.error    <= 1'b0;
      end else begin
        op_q.resp_due <= (cur_kind == cbus_pkg::CMD_WRITE_NON_POSTED) && i_mdata_last;
        op_q.last     <= i_mdata_last;
        op_q.error    <= i_mdata_last && (cnt_next != len_q);
      end
    end
  end

  assign op_out.valid = op_valid;
  assign op_out.op    = op_q;

endmodule

/* src/cbus_if.sv */
/*
 * internal stage links of the memory target
 *   operation link from intake to engine
 *   response beat link from engine to issuer
 */

interface cbus_op_if;
  logic              valid;
  logic              ready;
  cbus_pkg::mem_op_t op;

  modport source (
    output valid, op,
    input  ready
  );

  modport sink (
    input  valid, op,
    output ready
  );
endinterface

interface cbus_rsp_if;
  logic                 valid;
  logic                 ready;
  cbus_pkg::resp_beat_t beat;

  modport source (
    output valid, beat,
    input  ready
  );

  modport sink (
    input  valid, beat,
    output ready
  );
endinterface

/* src/cbus_mem_engine.sv */
/*
 * memory engine
 *   word array with byte enable writes
 *   in-order execution, response beat register
 */
`include "cbus_consts.svh"

module cbus_mem_engine (
  input  logic       clk,
  input  logic       i_rst_n,
  cbus_op_if.sink    op_in,
  cbus_rsp_if.source rsp_out
);
  localparam int BE_W = `CBUS_DATA_W / 8;

  logic [`CBUS_DATA_W-1:0] mem [`CBUS_MEM_DEPTH];
  logic                    rsp_valid;
  cbus_pkg::resp_beat_t    rsp_q;
  logic                    op_fire;
  logic                    op_write;

  // stall while the held beat has not moved on
  assign op_in.ready = !rsp_valid || rsp_out.ready;
  assign op_fire     = op_in.valid && op_in.ready;
  assign op_write    = op_in.op.kind != cbus_pkg::CMD_READ;

  // ##################
  // memory array
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `CBUS_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (op_fire && op_write) begin
      for (int b = 0; b < BE_W; b++) begin
        if (op_in.op.be[b]) begin
          mem[op_in.op.addr][8*b +: 8] <= op_in.op.data[8*b +: 8];
        end
      end
    end
  end

  // ##################
  // response beat
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid <= 1'b0;
    end else if (op_fire && op_in.op.resp_due) begin
      rsp_valid <= 1'b1;
    end else if (rsp_out.ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (op_fire && op_in.op.resp_due) begin
      rsp_q.id    <= op_in.op.id;
      rsp_q.last  <= op_in.op.last;
      rsp_q.error <= op_in.op.error;
      if (op_write) begin
        rsp_q.kind <= cbus_pkg::RESP_PLAIN;
        rsp_q.data <= '0;
      end else begin
        rsp_q.kind <= cbus_pkg::RESP_WITH_DATA;
        rsp_q.data <= mem[op_in.op.addr];
      end
    end
  end

  assign rsp_out.valid = rsp_valid;
  assign rsp_out.beat  = rsp_q;

endmodule

/* src/cbus_mem_target.sv */
/*
 * core bus memory target top level
 *   intake, memory engine and response issuer
 */
`include "cbus_consts.svh"

module cbus_mem_target (
  input  logic                      clk,
  input  logic                      i_rst_n,
  // command channel
  input  logic                      i_mcmd_valid,
  input  cbus_pkg::cmd_kind_e       i_mcmd_kind,
  input  logic [`CBUS_ID_W-1:0]     i_mcmd_id,
  input  logic [`CBUS_ADDR_W-1:0]   i_mcmd_addr,
  input  logic [`CBUS_LEN_W-1:0]    i_mcmd_len,
  output logic                      o_scmd_accept,
  // write data channel
  input  logic                      i_mdata_valid,
  input  logic [`CBUS_DATA_W-1:0]   i_mdata,
  input  logic [`CBUS_DATA_W/8-1:0] i_mdata_be,
  input  logic                      i_mdata_last,
  output logic                      o_sdata_accept,
  // response channel
  output logic                      o_sresp_valid,
  output cbus_pkg::resp_kind_e      o_sresp_kind,
  output logic [`CBUS_ID_W-1:0]     o_sresp_id,
  output logic [`CBUS_DATA_W-1:0]   o_sresp_data,
  output logic                      o_sresp_error,
  output logic                      o_sresp_last,
  input  logic                      i_mresp_accept
);
  cbus_op_if  op_link ();
  cbus_rsp_if rsp_link ();

  cbus_cmd_intake u_intake (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_mcmd_valid   (i_mcmd_valid),
    .i_mcmd_kind    (i_mcmd_kind),
    .i_mcmd_id      (i_mcmd_id),
    .i_mcmd_addr    (i_mcmd_addr),
    .i_mcmd_len     (i_mcmd_len),
    .o_scmd_accept  (o_scmd_accept),
    .i_mdata_valid  (i_mdata_valid),
    .i_mdata        (i_mdata),
    .i_mdata_be     (i_mdata_be),
    .i_mdata_last   (i_mdata_last),
    .o_sdata_accept (o_sdata_accept),
    .op_out         (op_link.source)
  );

  cbus_mem_engine u_engine (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .op_in   (op_link.sink),
    .rsp_out (rsp_link.source)
  );

  cbus_resp_issuer u_issuer (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .rsp_in         (rsp_link.sink),
    .o_sresp_valid  (o_sresp_valid),
    .o_sresp_kind   (o_sresp_kind),
    .o_sresp_id     (o_sresp_id),
    .o_sresp_data   (o_sresp_data),
    .o_sresp_error  (o_sresp_error),
    .o_sresp_last   (o_sresp_last),
    .i_mresp_accept (i_mresp_accept)
  );

endmodule

/* src/cbus_pkg.sv */
/*
 * core bus memory target types
 *   command and response kind enums
 *   memory operation and response beat structs
 */
`include "cbus_consts.svh"

package cbus_pkg;

  typedef enum logic [1:0] {
    CMD_READ             = 2'd0,
    CMD_WRITE_POSTED     = 2'd1,
    CMD_WRITE_NON_POSTED = 2'd2
  } cmd_kind_e;

  typedef enum logic {
    RESP_PLAIN     = 1'b0,
    RESP_WITH_DATA = 1'b1
  } resp_kind_e;

  // one word of work for the memory engine
  typedef struct packed {
    cmd_kind_e                 kind;
    logic [`CBUS_ID_W-1:0]     id;
    logic [`CBUS_ADDR_W-1:0]   addr;
    logic [`CBUS_DATA_W-1:0]   data;
    logic [`CBUS_DATA_W/8-1:0] be;
    logic                      resp_due;
    logic                      last;
    logic                      error;
  } mem_op_t;

  typedef struct packed {
    resp_kind_e                kind;
    logic [`CBUS_ID_W-1:0]     id;
    logic [`CBUS_DATA_W-1:0]   data;
    logic                      error;
    logic                      last;
  } resp_beat_t;

endpackage

/* src/cbus_resp_issuer.sv */
/*
 * response issuer
 *   two entry skid buffer onto the response channel
 */
`include "cbus_consts.svh"

module cbus_resp_issuer (
  input  logic                    clk,
  input  logic                    i_rst_n,
  cbus_rsp_if.sink                rsp_in,
  output logic                    o_sresp_valid,
  output cbus_pkg::resp_kind_e    o_sresp_kind,
  output logic [`CBUS_ID_W-1:0]   o_sresp_id,
  output logic [`CBUS_DATA_W-1:0] o_sresp_data,
  output logic                    o_sresp_error,
  output logic                    o_sresp_last,
  input  logic                    i_mresp_accept
);
  logic                 out_valid;
  logic                 skid_valid;
  cbus_pkg::resp_beat_t out_q;
  cbus_pkg::resp_beat_t skid_q;
  logic                 take;
  logic                 out_free;

  // ready comes from a flop, so no path runs back from the bus accept
  assign rsp_in.ready = !skid_valid;
  assign take         = rsp_in.valid && rsp_in.ready;
  assign out_free     = !out_valid || i_mresp_accept;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || take;
      skid_valid <= 1'b0;
    end else if (take) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_q <= skid_valid ? skid_q : rsp_in.beat;
    end else if (take) begin
      skid_q <= rsp_in.beat;
    end
  end

  assign o_sresp_valid = out_valid;
  assign o_sresp_kind  = out_q.kind;
  assign o_sresp_id    = out_q.id;
  assign o_sresp_data  = out_q.data;
  assign o_sresp_error = out_q.error;
  assign o_sresp_last  = out_q.last;

endmodule

/* test/cbus_target_props.sv */
/*
 * bus protocol properties of the memory target
 *   response hold, reset, kind and beat count rules
 */
`include "cbus_consts.svh"

module cbus_target_props (
  input logic                    clk,
  input logic                    i_rst_n,
  input logic                    i_mcmd_valid,
  input cbus_pkg::cmd_kind_e     i_mcmd_kind,
  input logic [`CBUS_LEN_W-1:0]  i_mcmd_len,
  input logic                    o_scmd_accept,
  input logic                    o_sdata_accept,
  input logic                    o_sresp_valid,
  input cbus_pkg::resp_kind_e    o_sresp_kind,
  input logic [`CBUS_ID_W-1:0]   o_sresp_id,
  input logic [`CBUS_DATA_W-1:0] o_sresp_data,
  input logic                    o_sresp_error,
  input logic                    o_sresp_last,
  input logic                    i_mresp_accept
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LEN_CNT_W = `CBUS_LEN_W + 1;

  // commands that owe a response, oldest at rd_ptr
  logic                 q_read [16];
  logic [LEN_CNT_W-1:0] q_len [16];
  logic [3:0]           wr_ptr;
  logic [3:0]           rd_ptr;
  logic [LEN_CNT_W-1:0] beat_cnt;
  logic                 cmd_owed;
  logic                 resp_fire;

  assign cmd_owed  = i_mcmd_valid && o_scmd_accept &&
                     (i_mcmd_kind != cbus_pkg::CMD_WRITE_POSTED);
  assign resp_fire = o_sresp_valid && i_mresp_accept;

  always_ff @(posedge clk) begin
    if (cmd_owed) begin
      q_read[wr_ptr] <= (i_mcmd_kind == cbus_pkg::CMD_READ);
      q_len[wr_ptr]  <= (i_mcmd_len == '0) ? LEN_CNT_W'(`CBUS_MAX_BURST) : LEN_CNT_W'(i_mcmd_len);
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      beat_cnt <= '0;
    end else begin
      if (cmd_owed) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (resp_fire) begin
        beat_cnt <= o_sresp_last ? '0 : beat_cnt + 1'b1;
        if (o_sresp_last) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // ####################
  // response channel rules
  a_resp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_sresp_valid && !i_mresp_accept |=> o_sresp_valid &&
      $stable({o_sresp_kind, o_sresp_id, o_sresp_data, o_sresp_error, o_sresp_last}))
    else $error("response payload moved before it was accepted");

  a_reset_quiet: assert property (@(posedge clk)
    !i_rst_n |-> !o_sresp_valid && !o_scmd_accept && !o_sdata_accept)
    else $error("valid or accept high during reset");

  // posted writes never push, so a beat without an entry follows one
  a_resp_owed: assert property (@(posedge clk) disable iff (!i_rst_n)
    resp_fire |-> (wr_ptr != rd_ptr))
    else $error("response without an outstanding command");

  a_resp_kind: assert property (@(posedge clk) disable iff (!i_rst_n)
    resp_fire |-> (o_sresp_kind ==
      (q_read[rd_ptr] ? cbus_pkg::RESP_WITH_DATA : cbus_pkg::RESP_PLAIN)))
    else $error("response kind does not match the command kind");

  a_resp_count: assert property (@(posedge clk) disable iff (!i_rst_n)
    resp_fire |-> (o_sresp_last ==
      (!q_read[rd_ptr] || (beat_cnt + 1'b1 == q_len[rd_ptr]))))
    else $error("response beat count differs from the burst length");

endmodule

bind cbus_mem_target cbus_target_props u_props (.*);

/* test/tb_cbus_mem_target.sv */
/*
 * testbench of the core bus memory target
 *   random commands and write data, random response back-pressure
 *   memory model with expected response queue, watchdog
 */
`include "cbus_consts.svh"

module tb_cbus_mem_target;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int N_CMDS     = 300;

  logic                      clk;
  logic                      i_rst_n;
  logic                      i_mcmd_valid;
  cbus_pkg::cmd_kind_e       i_mcmd_kind;
  logic [`CBUS_ID_W-1:0]     i_mcmd_id;
  logic [`CBUS_ADDR_W-1:0]   i_mcmd_addr;
  logic [`CBUS_LEN_W-1:0]    i_mcmd_len;
  logic                      o_scmd_accept;
  logic                      i_mdata_valid;
  logic [`CBUS_DATA_W-1:0]   i_mdata;
  logic [`CBUS_DATA_W/8-1:0] i_mdata_be;
  logic                      i_mdata_last;
  logic                      o_sdata_accept;
  logic                      o_sresp_valid;
  cbus_pkg::resp_kind_e      o_sresp_kind;
  logic [`CBUS_ID_W-1:0]     o_sresp_id;
  logic [`CBUS_DATA_W-1:0]   o_sresp_data;
  logic                      o_sresp_error;
  logic                      o_sresp_last;
  logic                      i_mresp_accept;

  logic [`CBUS_DATA_W-1:0] model_mem [`CBUS_MEM_DEPTH];
  cbus_pkg::resp_beat_t    exp_q [$];

  cbus_mem_target dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // ####################
  // compare tasks
  task automatic check_resp_kind(input cbus_pkg::resp_kind_e got,
                                 input cbus_pkg::resp_kind_e exp);
    if (got !== exp) begin
      $display("FAIL o_sresp_kind got 0x%0h expected 0x%0h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp_id(input logic [`CBUS_ID_W-1:0] got,
                               input logic [`CBUS_ID_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL o_sresp_id got 0x%0h expected 0x%0h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp_data(input logic [`CBUS_DATA_W-1:0] got,
                                 input logic [`CBUS_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL o_sresp_data got 0x%08h expected 0x%08h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp_flags(input logic got_error, input logic got_last,
                                  input logic exp_error, input logic exp_last);
    if (got_error !== exp_error) begin
      $display("FAIL o_sresp_error got 0x%0h expected 0x%0h", got_error, exp_error);
      abort_run();
    end else if (got_last !== exp_last) begin
      $display("FAIL o_sresp_last got 0x%0h expected 0x%0h", got_last, exp_last);
      abort_run();
    end
  endtask

  function automatic void push_expected(input cbus_pkg::resp_kind_e kind,
                                        input logic [`CBUS_ID_W-1:0] id,
                                        input logic [`CBUS_DATA_W-1:0] data,
                                        input logic error, input logic last);
    cbus_pkg::resp_beat_t beat;
    beat.kind  = kind;
    beat.id    = id;
    beat.data  = data;
    beat.error = error;
    beat.last  = last;
    exp_q.push_back(beat);
  endfunction

  task automatic compare_beat();
    cbus_pkg::resp_beat_t exp;
    if (exp_q.size() == 0) begin
      $display("response beat arrived while no response was outstanding");
      abort_run();
    end else begin
      exp = exp_q.pop_front();
      check_resp_kind(o_sresp_kind, exp.kind);
      check_resp_id(o_sresp_id, exp.id);
      if (exp.kind == cbus_pkg::RESP_WITH_DATA) begin
        check_resp_data(o_sresp_data, exp.data);
      end
      check_resp_flags(o_sresp_error, o_sresp_last, exp.error, exp.last);
    end
  endtask

  // ####################
  // stimulus
  task automatic send_write_data(input cbus_pkg::cmd_kind_e kind,
                                 input logic [`CBUS_ID_W-1:0] id,
                                 input logic [`CBUS_ADDR_W-1:0] addr,
                                 input int len_eff, input int n_beats);
    logic [`CBUS_ADDR_W-1:0]   a;
    logic [`CBUS_DATA_W-1:0]   word;
    logic [`CBUS_DATA_W/8-1:0] be;
    a = addr;
    for (int i = 0; i < n_beats; i++) begin
      repeat ($urandom_range(0, 2)) next_cycle();
      word          = $urandom();
      be            = $urandom_range(0, 15);
      i_mdata_valid = 1'b1;
      i_mdata       = word;
      i_mdata_be    = be;
      i_mdata_last  = (i == n_beats - 1);
      @(negedge clk);
      while (!o_sdata_accept) @(negedge clk);
      // beats past the length still land in memory
      for (int b = 0; b < `CBUS_DATA_W / 8; b++) begin
        if (be[b]) begin
          model_mem[a][8*b +: 8] = word[8*b +: 8];
        end
      end
      a = a + 1'b1;
      next_cycle();
      i_mdata_valid = 1'b0;
    end
    if (kind == cbus_pkg::CMD_WRITE_NON_POSTED) begin
      push_expected(cbus_pkg::RESP_PLAIN, id, '0, n_beats != len_eff, 1'b1);
    end
  endtask

  task automatic issue_command(input cbus_pkg::cmd_kind_e kind,
                               input logic [`CBUS_ID_W-1:0] id,
                               input logic [`CBUS_ADDR_W-1:0] addr,
                               input logic [`CBUS_LEN_W-1:0] len);
    int                      len_eff;
    int                      n_beats;
    logic [`CBUS_ADDR_W-1:0] a;
    len_eff = (len == 0) ? `CBUS_MAX_BURST : len;
    repeat ($urandom_range(0, 2)) next_cycle();
    i_mcmd_valid = 1'b1;
    i_mcmd_kind  = kind;
    i_mcmd_id    = id;
    i_mcmd_addr  = addr;
    i_mcmd_len   = len;
    @(negedge clk);
    while (!o_scmd_accept) @(negedge clk);
    if (kind == cbus_pkg::CMD_READ) begin
      a = addr;
      for (int i = 0; i < len_eff; i++) begin
        push_expected(cbus_pkg::RESP_WITH_DATA, id, model_mem[a], 1'b0, i == len_eff - 1);
        a = a + 1'b1;
      end
    end
    next_cycle();
    i_mcmd_valid = 1'b0;
    if (kind != cbus_pkg::CMD_READ) begin
      n_beats = len_eff;
      // roughly one write in eight gets a wrong beat count
      if ($urandom_range(0, 7) == 0) begin
        n_beats = $urandom_range(1, `CBUS_MAX_BURST + 2);
        if (n_beats == len_eff) begin
          n_beats = len_eff + 1;
        end
      end
      send_write_data(kind, id, addr, len_eff, n_beats);
    end
  endtask

  initial begin : main_seq
    int drain;
    void'($urandom(62027));
    i_rst_n       = 1'b0;
    i_mcmd_valid  = 1'b0;
    i_mcmd_kind   = cbus_pkg::CMD_READ;
    i_mcmd_id     = '0;
    i_mcmd_addr   = '0;
    i_mcmd_len    = '0;
    i_mdata_valid = 1'b0;
    i_mdata       = '0;
    i_mdata_be    = '0;
    i_mdata_last  = 1'b0;
    for (int i = 0; i < `CBUS_MEM_DEPTH; i++) begin
      model_mem[i] = '0;
    end
    repeat (2) begin
      next_cycle();
      if (o_sresp_valid || o_scmd_accept || o_sdata_accept) begin
        $display("a valid or accept output is high during reset");
        abort_run();
      end
    end
    i_rst_n = 1'b1;
    for (int c = 0; c < N_CMDS; c++) begin
      issue_command(cbus_pkg::cmd_kind_e'($urandom_range(0, 2)), $urandom_range(0, 15),
                    $urandom_range(0, `CBUS_MEM_DEPTH - 1), $urandom_range(0, 7));
    end
    drain = 0;
    while (exp_q.size() != 0 && drain < 2000) begin
      @(negedge clk);
      drain++;
    end
    // extra cycles catch stray beats after the last expected one
    repeat (20) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      abort_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // response side with random back-pressure
  initial begin : resp_side
    i_mresp_accept = 1'b0;
    @(posedge i_rst_n);
    forever begin
      next_cycle();
      i_mresp_accept = ($urandom_range(0, 9) < 7);
      @(negedge clk);
      if (o_sresp_valid && i_mresp_accept) begin
        compare_beat();
      end
    end
  end

  initial begin : watchdog
    #(N_CMDS * 40 * CLK_PERIOD);
    $display("watchdog expired before the test finished");
    abort_run();
  end

endmodule
